// ==== sources.f ====
+incdir+hdl
+incdir+sim
hdl/mmu_pkg.sv
hdl/tlb_array.sv
hdl/tlb_match.sv
hdl/addr_xlate.sv
hdl/mmu_top.sv
sim/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mmu_pkg.sv
      - hdl/tlb_array.sv
      - hdl/tlb_match.sv
      - hdl/addr_xlate.sv
      - hdl/mmu_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/mmu_tb.sv

// ==== sim/mmu_model.svh ====
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// shadow copy of the tlb entries
logic  sh_e    [`TLB_NUM];
vppn_t sh_vppn [`TLB_NUM];
ps_t   sh_ps   [`TLB_NUM];
asid_t sh_asid [`TLB_NUM];
logic  sh_g    [`TLB_NUM];
ppn_t  sh_ppn  [`TLB_NUM][2];
plv_t  sh_plv  [`TLB_NUM][2];
logic  sh_d    [`TLB_NUM][2];
logic  sh_v    [`TLB_NUM][2];

// vppn compared only above the page size
function automatic logic page_hit(int i, va_t va);
  if (sh_ps[i] == `PS_4M) begin
    return sh_vppn[i][18:9] == va[31:22];
  end
  return sh_vppn[i] == va[31:13];
endfunction

function automatic logic window_ok(logic [2:0] vseg, logic en0, logic en3, va_t va);
  return (va[31:29] == vseg) && ((cur_plv == 2'd0 && en0) || (cur_plv == 2'd3 && en3));
endfunction

function automatic void xlate_ref(va_t va, logic store, output pa_t pa, output xlate_excp_t ex);
  int hit;
  int pg;
  hit = -1;
  pa = va;
  ex = XE_NONE;
  if (crmd_da) return;
  if (window_ok(dmw0_vseg, dmw0_plv0, dmw0_plv3, va)) begin
    pa = {dmw0_pseg, va[28:0]};
    return;
  end
  if (window_ok(dmw1_vseg, dmw1_plv0, dmw1_plv3, va)) begin
    pa = {dmw1_pseg, va[28:0]};
    return;
  end
  for (int i = 0; i < `TLB_NUM; i++) begin
    if (sh_e[i] && (sh_g[i] || sh_asid[i] == cur_asid) && page_hit(i, va)) hit = i;
  end
  if (hit < 0) begin
    ex = XE_REFILL;
    return;
  end
  pg = (sh_ps[hit] == `PS_4M) ? va[21] : va[12];
  if (!sh_v[hit][pg]) ex = store ? XE_PIS : XE_PIL;
  else if (cur_plv > sh_plv[hit][pg]) ex = XE_PPI;
  else if (store && !sh_d[hit][pg]) ex = XE_PME;
  if (sh_ps[hit] == `PS_4M) pa = {sh_ppn[hit][pg][19:9], va[20:0]};
  else pa = {sh_ppn[hit][pg], va[11:0]};
endfunction

function automatic void inv_ref(logic [4:0] op, asid_t asid, va_t va);
  logic clr;
  logic ah;
  for (int i = 0; i < `TLB_NUM; i++) begin
    ah = (sh_asid[i] == asid);
    case (op)
      0, 1: clr = 1'b1;
      2: clr = sh_g[i];
      3: clr = !sh_g[i];
      4: clr = !sh_g[i] && ah;
      5: clr = !sh_g[i] && ah && page_hit(i, va);
      6: clr = (sh_g[i] || ah) && page_hit(i, va);
      default: clr = 1'b0;
    endcase
    if (clr) sh_e[i] = 1'b0;
  end
endfunction

function automatic void write_ref();
  sh_e[w_index]      = w_e;
  sh_vppn[w_index]   = w_vppn;
  sh_ps[w_index]     = w_ps;
  sh_asid[w_index]   = w_asid;
  sh_g[w_index]      = w_g;
  sh_ppn[w_index][0] = w_ppn0;
  sh_plv[w_index][0] = w_plv0;
  sh_d[w_index][0]   = w_d0;
  sh_v[w_index][0]   = w_v0;
  sh_ppn[w_index][1] = w_ppn1;
  sh_plv[w_index][1] = w_plv1;
  sh_d[w_index][1]   = w_d1;
  sh_v[w_index][1]   = w_v1;
endfunction

task automatic check_pa(string what, pa_t got, pa_t exp);
  if (got !== exp) begin
    $display("Mismatch at %0t ns: %s pa %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic check_excp(string what, xlate_excp_t got, xlate_excp_t exp);
  if (got !== exp) begin
    $display("Mismatch at %0t ns: %s excp %s, expected %s", $time, what, got.name(), exp.name());
    errors++;
  end
endtask

task automatic check_entry(tlb_idx_t idx);
  logic [84:0] got;
  logic [84:0] exp;
  got = {r_e, r_vppn, r_ps, r_asid, r_g, r_ppn0, r_plv0, r_d0, r_v0,
         r_ppn1, r_plv1, r_d1, r_v1};
  exp = {sh_e[idx], sh_vppn[idx], sh_ps[idx], sh_asid[idx], sh_g[idx],
         sh_ppn[idx][0], sh_plv[idx][0], sh_d[idx][0], sh_v[idx][0],
         sh_ppn[idx][1], sh_plv[idx][1], sh_d[idx][1], sh_v[idx][1]};
  if (got !== exp) begin
    $display("Mismatch at %0t ns: entry %0d read %h, expected %h", $time, idx, got, exp);
    errors++;
  end
endtask

`endif

// ==== sim/mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_tb import mmu_pkg::*; ();

  localparam int TEST_CYCLES = 450;

  logic aclk, rst;
  logic crmd_da, crmd_pg;
  plv_t cur_plv;
  asid_t cur_asid;
  logic [2:0] dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
  logic dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3;
  logic if_req, if_rsp_valid, dt_req, dt_store, dt_rsp_valid;
  va_t if_va, dt_va;
  pa_t if_pa, dt_pa;
  xlate_excp_t if_excp, dt_excp;
  logic tlb_we, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
  tlb_idx_t w_index, r_index;
  vppn_t w_vppn, r_vppn;
  ps_t w_ps, r_ps;
  asid_t w_asid, r_asid, invtlb_asid;
  ppn_t w_ppn0, w_ppn1, r_ppn0, r_ppn1;
  plv_t w_plv0, w_plv1, r_plv0, r_plv1;
  logic r_e, r_g, r_d0, r_v0, r_d1, r_v1;
  logic invtlb_valid;
  logic [4:0] invtlb_op;
  va_t invtlb_va;

  int errors = 0;
  int req_count = 0;
  int rsp_count = 0;
  int seed = 30143;
  pa_t if_pa_q[$], dt_pa_q[$];
  xlate_excp_t if_ex_q[$], dt_ex_q[$];

  `include "mmu_model.svh"

  mmu_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  initial begin : watchdog
    #(40.0 * 1.5 * TEST_CYCLES);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check_port(string name, logic valid, pa_t pa, xlate_excp_t ex,
                            ref pa_t pq[$], ref xlate_excp_t xq[$]);
    pa_t ep;
    xlate_excp_t ee;
    if (valid === 1'b1) begin
      if (pq.size() == 0) begin
        $display("%s port gave a response with no request at %0t ns", name, $time);
        errors++;
      end else begin
        ep = pq.pop_front();
        ee = xq.pop_front();
        rsp_count++;
        check_excp(name, ex, ee);
        if (ee == XE_NONE) check_pa(name, pa, ep);
      end
    end else if (valid !== 1'b0) begin
      $display("%s port response valid is unknown at %0t ns", name, $time);
      errors++;
    end else if (pq.size() != 0) begin
      $display("%s port gave no response for a request at %0t ns", name, $time);
      errors++;
      pq.delete();
      xq.delete();
    end
  endtask

  // predict at the edge, then check once outputs settle
  initial begin : compare
    pa_t p;
    xlate_excp_t x;
    forever begin
      @(posedge aclk);
      if (rst) begin
        for (int i = 0; i < `TLB_NUM; i++) sh_e[i] = 1'b0;
      end else begin
        if (if_req) begin
          xlate_ref(if_va, 1'b0, p, x);
          if_pa_q.push_back(p);
          if_ex_q.push_back(x);
          req_count++;
        end
        if (dt_req) begin
          xlate_ref(dt_va, dt_store, p, x);
          dt_pa_q.push_back(p);
          dt_ex_q.push_back(x);
          req_count++;
        end
        // write lands after the clear so it wins for its index
        if (invtlb_valid) inv_ref(invtlb_op, invtlb_asid, invtlb_va);
        if (tlb_we) write_ref();
      end
      @(negedge aclk);
      check_port("fetch", if_rsp_valid, if_pa, if_excp, if_pa_q, if_ex_q);
      check_port("data", dt_rsp_valid, dt_pa, dt_excp, dt_pa_q, dt_ex_q);
    end
  end

  function automatic va_t rand_va();
    return $random(seed);
  endfunction

  function automatic va_t va_in(int i);
    va_t r;
    r = $random(seed);
    if (sh_ps[i] == `PS_4M) return {sh_vppn[i][18:9], r[21:0]};
    return {sh_vppn[i], r[12:0]};
  endfunction

  task automatic clear_strobes();
    if_req <= 1'b0;
    dt_req <= 1'b0;
    dt_store <= 1'b0;
    tlb_we <= 1'b0;
    invtlb_valid <= 1'b0;
  endtask

  task automatic idle();
    @(posedge aclk);
    clear_strobes();
  endtask

  task automatic set_cfg(logic da, plv_t plv, asid_t asid);
    idle();
    crmd_da <= da;
    crmd_pg <= !da;
    cur_plv <= plv;
    cur_asid <= asid;
  endtask

  task automatic lookup(va_t iva, va_t dva, logic st);
    idle();
    if_req <= 1'b1;
    if_va <= iva;
    dt_req <= 1'b1;
    dt_va <= dva;
    dt_store <= st;
  endtask

  // pbits holds plv0, d0, v0, plv1, d1, v1
  task automatic write_entry(tlb_idx_t idx, vppn_t vp, ps_t ps, asid_t asid, logic g,
                             logic [7:0] pbits);
    ppn_t pn;
    pn = $random(seed);
    idle();
    tlb_we <= 1'b1;
    w_index <= idx;
    w_e <= 1'b1;
    w_vppn <= vp;
    w_ps <= ps;
    w_asid <= asid;
    w_g <= g;
    w_ppn0 <= pn;
    w_ppn1 <= ~pn;
    {w_plv0, w_d0, w_v0, w_plv1, w_d1, w_v1} <= pbits;
  endtask

  // top vppn bits carry the index so no two entries overlap
  task automatic rand_write(tlb_idx_t idx);
    logic [31:0] r;
    r = $random(seed);
    write_entry(idx, {idx, r[14:0]}, r[15] ? ps_t'(`PS_4M) : ps_t'(`PS_4K),
                asid_t'(r[17:16]), r[18], r[26:19]);
  endtask

  task automatic read_and_lookup(tlb_idx_t idx, va_t iva, va_t dva, logic st);
    lookup(iva, dva, st);
    r_index <= idx;
    @(negedge aclk);
    check_entry(idx);
  endtask

  task automatic end_test(string name, int start_err);
    $display("%s finished with %0d errors", name, errors - start_err);
  endtask

  initial begin : stimulus
    int e0;
    va_t vas[`TLB_NUM];
    int k;
    va_t seg_va;
    crmd_da = 1'b1;
    crmd_pg = 1'b0;
    cur_plv = '0;
    cur_asid = '0;
    {dmw0_vseg, dmw0_pseg, dmw0_plv0, dmw0_plv3} = '0;
    {dmw1_vseg, dmw1_pseg, dmw1_plv0, dmw1_plv3} = '0;
    // requests held through reset must not produce a response
    {if_req, dt_req} = 2'b11;
    {dt_store, if_va, dt_va} = '0;
    {tlb_we, w_index, w_e, w_vppn, w_ps, w_asid, w_g} = '0;
    {w_ppn0, w_plv0, w_d0, w_v0, w_ppn1, w_plv1, w_d1, w_v1} = '0;
    r_index = '0;
    {invtlb_valid, invtlb_op, invtlb_asid, invtlb_va} = '0;
    rst = 1'b1;
    repeat (3) @(posedge aclk);
    rst <= 1'b0;
    if_req <= 1'b0;
    dt_req <= 1'b0;

    e0 = errors;
    for (int i = 0; i < 6; i++) lookup(rand_va(), rand_va(), i[0]);
    set_cfg(1'b0, 2'd0, '0);
    dmw0_vseg <= 3'd4;
    dmw0_pseg <= 3'd1;
    dmw0_plv0 <= 1'b1;
    dmw1_vseg <= 3'd4;
    dmw1_pseg <= 3'd2;
    dmw1_plv0 <= 1'b1;
    dmw1_plv3 <= 1'b1;
    for (int p = 0; p < 4; p++) begin
      set_cfg(1'b0, plv_t'(p), '0);
      for (int i = 0; i < 4; i++) begin
        seg_va = rand_va();
        lookup({3'd4, seg_va[28:0]}, rand_va(), 1'b0);
      end
    end
    set_cfg(1'b0, 2'd0, '0);
    {dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3} <= '0;
    end_test("direct mode and windows", e0);

    e0 = errors;
    for (int i = 0; i < `TLB_NUM; i++) rand_write(tlb_idx_t'(i));
    idle();
    @(negedge aclk);
    for (int i = 0; i < `TLB_NUM; i++) vas[i] = va_in(i);
    for (int i = 0; i < `TLB_NUM; i++) begin
      read_and_lookup(tlb_idx_t'(i), vas[i], vas[`TLB_NUM-1-i], i[1]);
    end
    for (int a = 1; a < 4; a++) begin
      set_cfg(1'b0, plv_t'(a - 1), asid_t'(a));
      for (int i = 0; i < 5; i++) lookup(vas[(i * 3 + a) % 16], vas[(i * 7) % 16], i[0]);
    end
    end_test("writes and lookups", e0);

    e0 = errors;
    idle();
    invtlb_valid <= 1'b1;
    invtlb_op <= 5'd0;
    write_entry(4'd0, 19'h12345, `PS_4K, 10'd0, 1'b1, 8'b00_0_0_00_0_1);
    write_entry(4'd1, 19'h22222, `PS_4K, 10'd0, 1'b1, 8'b00_1_1_00_1_1);
    set_cfg(1'b0, 2'd0, '0);
    lookup({19'h12345, 13'h0100}, {19'h12345, 13'h0100}, 1'b1);
    lookup({19'h7ffff, 13'h0000}, {19'h12345, 13'h1100}, 1'b1);
    lookup({19'h22222, 13'h0040}, {19'h22222, 13'h0040}, 1'b1);
    set_cfg(1'b0, 2'd3, '0);
    lookup({19'h12345, 13'h1100}, {19'h12345, 13'h1100}, 1'b1);
    end_test("faults", e0);

    e0 = errors;
    write_entry(4'd2, 19'h33333, `PS_4K, 10'd7, 1'b1, 8'hff);
    write_entry(4'd3, 19'h44444, `PS_4M, 10'd5, 1'b0, 8'hff);
    for (int a = 0; a < 2; a++) begin
      set_cfg(1'b0, 2'd0, a ? 10'd9 : 10'd5);
      lookup({19'h33333, 13'h1abc}, {19'h44444, 13'h0abc}, 1'b0);
      lookup({19'h44444, 13'h1abc}, {19'h33333, 13'h0abc}, 1'b1);
    end
    end_test("global and asid matching", e0);

    e0 = errors;
    set_cfg(1'b0, 2'd0, 10'd1);
    for (int op = 0; op < 8; op++) begin
      for (int i = 0; i < `TLB_NUM; i++) rand_write(tlb_idx_t'(i));
      idle();
      @(negedge aclk);
      for (int i = 0; i < `TLB_NUM; i++) vas[i] = va_in(i);
      k = $unsigned($random(seed)) % `TLB_NUM;
      idle();
      invtlb_valid <= 1'b1;
      invtlb_op <= 5'(op);
      invtlb_asid <= sh_asid[k];
      invtlb_va <= vas[k];
      idle();
      @(negedge aclk);
      for (int i = 0; i < `TLB_NUM; i++) begin
        read_and_lookup(tlb_idx_t'(i), vas[i], vas[(i + 5) % 16], 1'b0);
      end
    end
    end_test("invtlb", e0);

    e0 = errors;
    for (int i = 0; i < 24; i++) lookup(vas[i % 16], rand_va(), i[0]);
    idle();
    idle();
    if (req_count != rsp_count) begin
      $display("%0d requests got only %0d responses", req_count, rsp_count);
      errors++;
    end
    end_test("back-to-back requests", e0);

    $display("summary: %0d requests, %0d responses checked, %0d errors",
             req_count, rsp_count, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module mmu_top import mmu_pkg::*; (
  input  logic        aclk,
  input  logic        rst,
  input  logic        crmd_da,
  input  logic        crmd_pg,
  input  plv_t        cur_plv,
  input  asid_t       cur_asid,
  input  logic [2:0]  dmw0_vseg,
  input  logic [2:0]  dmw0_pseg,
  input  logic        dmw0_plv0,
  input  logic        dmw0_plv3,
  input  logic [2:0]  dmw1_vseg,
  input  logic [2:0]  dmw1_pseg,
  input  logic        dmw1_plv0,
  input  logic        dmw1_plv3,
  input  logic        if_req,
  input  va_t         if_va,
  output logic        if_rsp_valid,
  output pa_t         if_pa,
  output xlate_excp_t if_excp,
  input  logic        dt_req,
  input  va_t         dt_va,
  input  logic        dt_store,
  output logic        dt_rsp_valid,
  output pa_t         dt_pa,
  output xlate_excp_t dt_excp,
  input  logic        tlb_we,
  input  tlb_idx_t    w_index,
  input  logic        w_e,
  input  vppn_t       w_vppn,
  input  ps_t         w_ps,
  input  asid_t       w_asid,
  input  logic        w_g,
  input  ppn_t        w_ppn0,
  input  plv_t        w_plv0,
  input  logic        w_d0,
  input  logic        w_v0,
  input  ppn_t        w_ppn1,
  input  plv_t        w_plv1,
  input  logic        w_d1,
  input  logic        w_v1,
  input  tlb_idx_t    r_index,
  output logic        r_e,
  output vppn_t       r_vppn,
  output ps_t         r_ps,
  output asid_t       r_asid,
  output logic        r_g,
  output ppn_t        r_ppn0,
  output plv_t        r_plv0,
  output logic        r_d0,
  output logic        r_v0,
  output ppn_t        r_ppn1,
  output plv_t        r_plv1,
  output logic        r_d1,
  output logic        r_v1,
  input  logic        invtlb_valid,
  input  logic [4:0]  invtlb_op,
  input  asid_t       invtlb_asid,
  input  va_t         invtlb_va
);

  logic  [`TLB_NUM-1:0] ent_e;
  vppn_t [`TLB_NUM-1:0] ent_vppn;
  ps_t   [`TLB_NUM-1:0] ent_ps;
  asid_t [`TLB_NUM-1:0] ent_asid;
  logic  [`TLB_NUM-1:0] ent_g;
  ppn_t  [`TLB_NUM-1:0] ent_ppn0;
  ppn_t  [`TLB_NUM-1:0] ent_ppn1;
  plv_t  [`TLB_NUM-1:0] ent_plv0;
  plv_t  [`TLB_NUM-1:0] ent_plv1;
  logic  [`TLB_NUM-1:0] ent_d0;
  logic  [`TLB_NUM-1:0] ent_d1;
  logic  [`TLB_NUM-1:0] ent_v0;
  logic  [`TLB_NUM-1:0] ent_v1;

  // fetch side lookup
  va_t   if_lookup_va;
  asid_t if_lookup_asid;
  logic  if_found;
  ppn_t  if_ppn;
  ps_t   if_ps;
  plv_t  if_plv;
  logic  if_d;
  logic  if_v;

  // data side lookup
  va_t   dt_lookup_va;
  asid_t dt_lookup_asid;
  logic  dt_found;
  ppn_t  dt_ppn;
  ps_t   dt_ps;
  plv_t  dt_plv;
  logic  dt_d;
  logic  dt_v;

  tlb_array u_tlb_array (.*);

  tlb_match u_if_match (
    .va    (if_lookup_va),
    .asid  (if_lookup_asid),
    .found (if_found),
    .ppn   (if_ppn),
    .ps    (if_ps),
    .plv   (if_plv),
    .d     (if_d),
    .v     (if_v),
    .*
  );

  tlb_match u_dt_match (
    .va    (dt_lookup_va),
    .asid  (dt_lookup_asid),
    .found (dt_found),
    .ppn   (dt_ppn),
    .ps    (dt_ps),
    .plv   (dt_plv),
    .d     (dt_d),
    .v     (dt_v),
    .*
  );

  // fetch never stores
  addr_xlate u_if_xlate (
    .req         (if_req),
    .va          (if_va),
    .store       (1'b0),
    .found       (if_found),
    .ppn         (if_ppn),
    .ps          (if_ps),
    .plv         (if_plv),
    .d           (if_d),
    .v           (if_v),
    .lookup_va   (if_lookup_va),
    .lookup_asid (if_lookup_asid),
    .rsp_valid   (if_rsp_valid),
    .pa          (if_pa),
    .excp        (if_excp),
    .*
  );

  addr_xlate u_dt_xlate (
    .req         (dt_req),
    .va          (dt_va),
    .store       (dt_store),
    .found       (dt_found),
    .ppn         (dt_ppn),
    .ps          (dt_ps),
    .plv         (dt_plv),
    .d           (dt_d),
    .v           (dt_v),
    .lookup_va   (dt_lookup_va),
    .lookup_asid (dt_lookup_asid),
    .rsp_valid   (dt_rsp_valid),
    .pa          (dt_pa),
    .excp        (dt_excp),
    .*
  );

endmodule

`default_nettype wire

// ==== hdl/addr_xlate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module addr_xlate import mmu_pkg::*; (
  input  logic        aclk,
  input  logic        rst,
  input  logic        req,
  input  va_t         va,
  input  logic        store,
  input  logic        crmd_da,
  input  logic        crmd_pg,
  input  plv_t        cur_plv,
  input  asid_t       cur_asid,
  input  logic [2:0]  dmw0_vseg,
  input  logic [2:0]  dmw0_pseg,
  input  logic        dmw0_plv0,
  input  logic        dmw0_plv3,
  input  logic [2:0]  dmw1_vseg,
  input  logic [2:0]  dmw1_pseg,
  input  logic        dmw1_plv0,
  input  logic        dmw1_plv3,
  input  logic        found,
  input  ppn_t        ppn,
  input  ps_t         ps,
  input  plv_t        plv,
  input  logic        d,
  input  logic        v,
  output va_t         lookup_va,
  output asid_t       lookup_asid,
  output logic        rsp_valid,
  output pa_t         pa,
  output xlate_excp_t excp
);

  logic        direct;
  logic        dmw0_hit;
  logic        dmw1_hit;
  pa_t         tlb_pa;
  pa_t         next_pa;
  xlate_excp_t tlb_excp;
  xlate_excp_t next_excp;

  assign lookup_va   = va;
  assign lookup_asid = cur_asid;

  assign direct = crmd_da || !crmd_pg;

  // window needs the segment and the enable for the current level
  assign dmw0_hit = (va[31:29] == dmw0_vseg)
                 && (((cur_plv == 2'd0) && dmw0_plv0) || ((cur_plv == 2'd3) && dmw0_plv3));
  assign dmw1_hit = (va[31:29] == dmw1_vseg)
                 && (((cur_plv == 2'd0) && dmw1_plv0) || ((cur_plv == 2'd3) && dmw1_plv3));

  // 4M page takes the low 21 bits from va
  assign tlb_pa = (ps == `PS_4M) ? {ppn[19:9], va[20:0]} : {ppn, va[11:0]};

  always_comb begin
    if (!found) begin
      tlb_excp = XE_REFILL;
    end else if (!v) begin
      tlb_excp = store ? XE_PIS : XE_PIL;
    end else if (cur_plv > plv) begin
      tlb_excp = XE_PPI;
    end else if (store && !d) begin
      tlb_excp = XE_PME;
    end else begin
      tlb_excp = XE_NONE;
    end
  end

  always_comb begin
    if (direct) begin
      next_pa   = va;
      next_excp = XE_NONE;
    end else if (dmw0_hit) begin
      next_pa   = {dmw0_pseg, va[28:0]};
      next_excp = XE_NONE;
    end else if (dmw1_hit) begin
      next_pa   = {dmw1_pseg, va[28:0]};
      next_excp = XE_NONE;
    end else begin
      next_pa   = tlb_pa;
      next_excp = tlb_excp;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req;
    end
  end

  always_ff @(posedge aclk) begin
    if (req) begin
      pa   <= next_pa;
      excp <= next_excp;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tlb_match.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_match import mmu_pkg::*; (
  input  va_t                     va,
  input  asid_t                   asid,
  input  logic  [`TLB_NUM-1:0]    ent_e,
  input  vppn_t [`TLB_NUM-1:0]    ent_vppn,
  input  ps_t   [`TLB_NUM-1:0]    ent_ps,
  input  asid_t [`TLB_NUM-1:0]    ent_asid,
  input  logic  [`TLB_NUM-1:0]    ent_g,
  input  ppn_t  [`TLB_NUM-1:0]    ent_ppn0,
  input  ppn_t  [`TLB_NUM-1:0]    ent_ppn1,
  input  plv_t  [`TLB_NUM-1:0]    ent_plv0,
  input  plv_t  [`TLB_NUM-1:0]    ent_plv1,
  input  logic  [`TLB_NUM-1:0]    ent_d0,
  input  logic  [`TLB_NUM-1:0]    ent_d1,
  input  logic  [`TLB_NUM-1:0]    ent_v0,
  input  logic  [`TLB_NUM-1:0]    ent_v1,
  output logic                    found,
  output ppn_t                    ppn,
  output ps_t                     ps,
  output plv_t                    plv,
  output logic                    d,
  output logic                    v
);

  logic [`TLB_NUM-1:0] hit;

  // all entries compared in parallel
  always_comb begin
    for (int i = 0; i < `TLB_NUM; i++) begin
      hit[i] = ent_e[i]
            && (ent_g[i] || (ent_asid[i] == asid))
            && ((ent_ps[i] == `PS_4M) ? (ent_vppn[i][18:9] == va[31:22])
                                      : (ent_vppn[i] == va[31:13]));
    end
  end

  assign found = |hit;

  always_comb begin
    logic odd;
    odd = 1'b0;
    ppn = '0;
    ps  = '0;
    plv = '0;
    d   = 1'b0;
    v   = 1'b0;
    for (int i = 0; i < `TLB_NUM; i++) begin
      if (hit[i]) begin
        // pair select bit sits just above the page offset
        odd = (ent_ps[i] == `PS_4K) ? va[12] : va[21];
        ps  = ent_ps[i];
        ppn = odd ? ent_ppn1[i] : ent_ppn0[i];
        plv = odd ? ent_plv1[i] : ent_plv0[i];
        d   = odd ? ent_d1[i] : ent_d0[i];
        v   = odd ? ent_v1[i] : ent_v0[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tlb_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_array import mmu_pkg::*; (
  input  logic                    aclk,
  input  logic                    rst,
  input  logic                    tlb_we,
  input  tlb_idx_t                w_index,
  input  logic                    w_e,
  input  vppn_t                   w_vppn,
  input  ps_t                     w_ps,
  input  asid_t                   w_asid,
  input  logic                    w_g,
  input  ppn_t                    w_ppn0,
  input  plv_t                    w_plv0,
  input  logic                    w_d0,
  input  logic                    w_v0,
  input  ppn_t                    w_ppn1,
  input  plv_t                    w_plv1,
  input  logic                    w_d1,
  input  logic                    w_v1,
  input  tlb_idx_t                r_index,
  output logic                    r_e,
  output vppn_t                   r_vppn,
  output ps_t                     r_ps,
  output asid_t                   r_asid,
  output logic                    r_g,
  output ppn_t                    r_ppn0,
  output plv_t                    r_plv0,
  output logic                    r_d0,
  output logic                    r_v0,
  output ppn_t                    r_ppn1,
  output plv_t                    r_plv1,
  output logic                    r_d1,
  output logic                    r_v1,
  input  logic                    invtlb_valid,
  input  logic [4:0]              invtlb_op,
  input  asid_t                   invtlb_asid,
  input  va_t                     invtlb_va,
  output logic  [`TLB_NUM-1:0]    ent_e,
  output vppn_t [`TLB_NUM-1:0]    ent_vppn,
  output ps_t   [`TLB_NUM-1:0]    ent_ps,
  output asid_t [`TLB_NUM-1:0]    ent_asid,
  output logic  [`TLB_NUM-1:0]    ent_g,
  output ppn_t  [`TLB_NUM-1:0]    ent_ppn0,
  output ppn_t  [`TLB_NUM-1:0]    ent_ppn1,
  output plv_t  [`TLB_NUM-1:0]    ent_plv0,
  output plv_t  [`TLB_NUM-1:0]    ent_plv1,
  output logic  [`TLB_NUM-1:0]    ent_d0,
  output logic  [`TLB_NUM-1:0]    ent_d1,
  output logic  [`TLB_NUM-1:0]    ent_v0,
  output logic  [`TLB_NUM-1:0]    ent_v1
);

  logic                inv_en;
  logic [`TLB_NUM-1:0] inv_hit;

  assign inv_en = invtlb_valid && (invtlb_op <= `INVTLB_OP_MAX);

  // per-entry clear decision for the current invtlb op
  always_comb begin
    logic asid_hit;
    logic va_hit;
    for (int i = 0; i < `TLB_NUM; i++) begin
      asid_hit = (ent_asid[i] == invtlb_asid);
      va_hit   = (ent_ps[i] == `PS_4M) ? (ent_vppn[i][18:9] == invtlb_va[31:22])
                                       : (ent_vppn[i] == invtlb_va[31:13]);
      case (invtlb_op)
        5'd0, 5'd1: inv_hit[i] = 1'b1;
        5'd2:       inv_hit[i] = ent_g[i];
        5'd3:       inv_hit[i] = !ent_g[i];
        5'd4:       inv_hit[i] = !ent_g[i] && asid_hit;
        5'd5:       inv_hit[i] = !ent_g[i] && asid_hit && va_hit;
        5'd6:       inv_hit[i] = (ent_g[i] || asid_hit) && va_hit;
        default:    inv_hit[i] = 1'b0;
      endcase
      inv_hit[i] = inv_hit[i] && inv_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      ent_e <= '0;
    end else begin
      ent_e <= ent_e & ~inv_hit;
      // write overrides a clear of its own index
      if (tlb_we) begin
        ent_e[w_index] <= w_e;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (tlb_we) begin
      ent_vppn[w_index] <= w_vppn;
      ent_ps[w_index]   <= w_ps;
      ent_asid[w_index] <= w_asid;
      ent_g[w_index]    <= w_g;
      ent_ppn0[w_index] <= w_ppn0;
      ent_plv0[w_index] <= w_plv0;
      ent_d0[w_index]   <= w_d0;
      ent_v0[w_index]   <= w_v0;
      ent_ppn1[w_index] <= w_ppn1;
      ent_plv1[w_index] <= w_plv1;
      ent_d1[w_index]   <= w_d1;
      ent_v1[w_index]   <= w_v1;
    end
  end

  assign r_e    = ent_e[r_index];
  assign r_vppn = ent_vppn[r_index];
  assign r_ps   = ent_ps[r_index];
  assign r_asid = ent_asid[r_index];
  assign r_g    = ent_g[r_index];
  assign r_ppn0 = ent_ppn0[r_index];
  assign r_plv0 = ent_plv0[r_index];
  assign r_d0   = ent_d0[r_index];
  assign r_v0   = ent_v0[r_index];
  assign r_ppn1 = ent_ppn1[r_index];
  assign r_plv1 = ent_plv1[r_index];
  assign r_d1   = ent_d1[r_index];
  assign r_v1   = ent_v1[r_index];

endmodule

`default_nettype wire

// ==== hdl/mmu_pkg.sv ====
`default_nettype none

`include "mmu_params.svh"

package mmu_pkg;

  typedef logic [`VA_W-1:0] va_t;
  typedef logic [`PA_W-1:0] pa_t;

  // one vppn covers an even/odd page pair
  typedef logic [`VA_W-14:0] vppn_t;
  typedef logic [`PA_W-13:0] ppn_t;

  typedef logic [9:0] asid_t;
  typedef logic [1:0] plv_t;
  typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;
  typedef logic [5:0] ps_t;

  typedef enum logic [2:0] {
    XE_NONE,
    XE_REFILL,
    XE_PIL,
    XE_PIS,
    XE_PPI,
    XE_PME
  } xlate_excp_t;

endpackage

`default_nettype wire

// ==== hdl/mmu_params.svh ====
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// tlb geometry
`define TLB_NUM 16
`define TLB_IDX_W 4

// page size codes as held in an entry
`define PS_4K 12
`define PS_4M 21

// address widths
`define VA_W 32
`define PA_W 32

// invtlb ops 0 to 6 are defined, anything higher is ignored
`define INVTLB_OP_MAX 6

`endif
